//--- verilog/ecc_rnd_settings.svh
// --------------------------------------
// word width, core rounds, FIFO depth
// and APB register offsets
// --------------------------------------
`ifndef ECC_RND_SETTINGS_SVH
`define ECC_RND_SETTINGS_SVH

// datapath word for operands and results
`define ECC_RND_W 32

// xorshift rounds per core command, one per cycle
`define ECC_RND_ROUNDS 4

// result buffer entries
`define ECC_RND_FIFO_DEPTH 4

// apb byte offsets
`define ECC_RND_ADDR_CTRL    8'h00
`define ECC_RND_ADDR_STATUS  8'h04
`define ECC_RND_ADDR_IV      8'h08
`define ECC_RND_ADDR_SEED    8'h0C
`define ECC_RND_ADDR_NONCE   8'h10
`define ECC_RND_ADDR_PRIVKEY 8'h14
`define ECC_RND_ADDR_HASH    8'h18
`define ECC_RND_ADDR_RESULT  8'h1C

`endif

//--- verilog/ecc_rnd_pkg.sv
// --------------------------------------
// shared types: result kind and entry,
// operand bundle, core command
// --------------------------------------
`include "ecc_rnd_settings.svh"

package ecc_rnd_pkg;

    // result tag, 0 kept free so an empty FIFO reads as kind 0
    typedef enum logic [2:0]
    {
        LAMBDA      = 3'd1,
        SCALAR_RND  = 3'd2,
        MASKING_RND = 3'd3,
        PRIVKEY     = 3'd4,
        SIGN_K      = 3'd5
    } rnd_kind_e;

    // one tagged result word
    typedef struct packed
    {
        rnd_kind_e             kind;
        logic [`ECC_RND_W-1:0] value;
    } rnd_result_t;

    // software operands plus mode, 1 means sign
    typedef struct packed
    {
        logic [`ECC_RND_W-1:0] iv;
        logic [`ECC_RND_W-1:0] seed;
        logic [`ECC_RND_W-1:0] nonce;
        logic [`ECC_RND_W-1:0] privkey;
        logic [`ECC_RND_W-1:0] hash;
        logic                  keygen_sign;
    } rnd_operands_t;

    // command into the generator core
    typedef struct packed
    {
        logic                  init;
        logic                  next;
        logic [`ECC_RND_W-1:0] entropy;
        logic [`ECC_RND_W-1:0] nonce;
    } drbg_cmd_t;

endpackage

//--- verilog/drbg_core.sv
// --------------------------------------
// keyed xorshift generator core
// --------------------------------------
`include "ecc_rnd_settings.svh"

module drbg_core
(
    input  logic                   clk,
    input  logic                   reset_n,
    input  ecc_rnd_pkg::drbg_cmd_t cmd,
    output logic                   ready,
    output logic                   valid,
    output logic [`ECC_RND_W-1:0]  result
);

    localparam int RCW = $clog2(`ECC_RND_ROUNDS + 1);

    logic [`ECC_RND_W-1:0] key_q;
    logic [`ECC_RND_W-1:0] counter_q;
    logic [`ECC_RND_W-1:0] mix_q;
    logic [RCW-1:0]        rounds_left_q;
    logic                  running_q;
    logic                  accept;
    logic [`ECC_RND_W-1:0] new_key;
    logic [`ECC_RND_W-1:0] new_counter;

    // one xorshift32 round
    function automatic logic [`ECC_RND_W-1:0] xorshift32(input logic [`ECC_RND_W-1:0] x);
        logic [`ECC_RND_W-1:0] t;
        t = x ^ (x << 13);
        t = t ^ (t >> 17);
        t = t ^ (t << 5);
        return t;
    endfunction

    // --------------------------------------
    // command decode
    // --------------------------------------
    // busy core drops commands
    assign accept = ready && (cmd.init || cmd.next);

    // init rekeys from entropy and rotated nonce
    assign new_key = cmd.init ?
        (cmd.entropy ^ {cmd.nonce[`ECC_RND_W-17:0], cmd.nonce[`ECC_RND_W-1:`ECC_RND_W-16]}) :
        key_q;
    // init restarts the counter, next steps it
    assign new_counter = cmd.init ? '0 : counter_q + `ECC_RND_W'(1);

    // control
    always_ff @(posedge clk or negedge reset_n)
    begin
        if (!reset_n)
        begin
            running_q     <= 1'b0;
            rounds_left_q <= '0;
            counter_q     <= '0;
            valid         <= 1'b0;
        end
        else
        begin
            valid <= 1'b0;
            if (accept)
            begin
                running_q     <= 1'b1;
                rounds_left_q <= RCW'(`ECC_RND_ROUNDS);
                counter_q     <= new_counter;
            end
            else if (running_q)
            begin
                rounds_left_q <= rounds_left_q - RCW'(1);
                // last round lands, result valid next cycle
                if (rounds_left_q == RCW'(1))
                begin
                    running_q <= 1'b0;
                    valid     <= 1'b1;
                end
            end
        end
    end

    // key and mixing state
    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            key_q <= new_key;
            mix_q <= new_key ^ (new_counter + `ECC_RND_W'(1));
        end
        else if (running_q)
        begin
            mix_q <= xorshift32(mix_q);
        end
    end

    assign ready  = !running_q;
    assign result = mix_q;

endmodule

//--- verilog/drbg_sequencer.sv
// --------------------------------------
// keygen / sign command sequencer
// --------------------------------------
`include "ecc_rnd_settings.svh"

module drbg_sequencer
(
    input  logic                       clk,
    input  logic                       reset_n,
    input  logic                       start,
    input  ecc_rnd_pkg::rnd_operands_t operands,
    input  logic                       core_ready,
    input  logic                       core_valid,
    input  logic [`ECC_RND_W-1:0]      core_result,
    output ecc_rnd_pkg::drbg_cmd_t     core_cmd,
    output logic                       push,
    output ecc_rnd_pkg::rnd_result_t   push_data,
    input  logic                       fifo_full,
    output logic                       busy,
    output logic [7:0]                 op_count
);

    typedef enum logic [2:0]
    {
        ST_IDLE,
        ST_LAMBDA,
        ST_SCALAR,
        ST_MASKING,
        ST_FINAL
    } seq_state_e;

    seq_state_e                 state_q;
    seq_state_e                 state_next;
    ecc_rnd_pkg::rnd_operands_t ops_q;
    logic                       issued_q;
    logic                       held_q;
    logic [`ECC_RND_W-1:0]      held_value_q;
    logic                       issue;

    // --------------------------------------
    // core command, once per stage
    // --------------------------------------
    assign issue = (state_q != ST_IDLE) && !issued_q && core_ready;

    always_comb
    begin
        core_cmd.init    = issue && (state_q == ST_LAMBDA || state_q == ST_FINAL);
        core_cmd.next    = issue && (state_q == ST_SCALAR || state_q == ST_MASKING);
        // iv stages nonce on the op counter
        core_cmd.entropy = ops_q.iv;
        core_cmd.nonce   = {{(`ECC_RND_W-8){1'b0}}, op_count};
        if (state_q == ST_FINAL)
        begin
            core_cmd.entropy = ops_q.keygen_sign ? ops_q.privkey : ops_q.seed;
            core_cmd.nonce   = ops_q.keygen_sign ? ops_q.hash : ops_q.nonce;
        end
    end

    // held result goes out only with a free slot
    assign push = held_q && !fifo_full;

    always_comb
    begin
        state_next          = state_q;
        push_data.kind      = ecc_rnd_pkg::LAMBDA;
        push_data.value     = held_value_q;
        unique case (state_q)
            ST_IDLE:    state_next = start ? ST_LAMBDA : ST_IDLE;
            ST_LAMBDA:  state_next = push ? ST_SCALAR : ST_LAMBDA;
            ST_SCALAR:
            begin
                push_data.kind = ecc_rnd_pkg::SCALAR_RND;
                if (push)
                    state_next = ops_q.keygen_sign ? ST_MASKING : ST_FINAL;
            end
            ST_MASKING:
            begin
                push_data.kind = ecc_rnd_pkg::MASKING_RND;
                state_next     = push ? ST_FINAL : ST_MASKING;
            end
            ST_FINAL:
            begin
                push_data.kind = ops_q.keygen_sign ? ecc_rnd_pkg::SIGN_K : ecc_rnd_pkg::PRIVKEY;
                state_next     = push ? ST_IDLE : ST_FINAL;
            end
            default:    state_next = ST_IDLE;
        endcase
    end

    // --------------------------------------
    // state and flags
    // --------------------------------------
    always_ff @(posedge clk or negedge reset_n)
    begin
        if (!reset_n)
        begin
            state_q  <= ST_IDLE;
            issued_q <= 1'b0;
            held_q   <= 1'b0;
            op_count <= 8'd0;
        end
        else
        begin
            state_q <= state_next;
            if (issue)
                issued_q <= 1'b1;
            if (core_valid)
                held_q <= 1'b1;
            // stage done, rearm for the next command
            if (push)
            begin
                issued_q <= 1'b0;
                held_q   <= 1'b0;
            end
            if (push && state_q == ST_FINAL)
                op_count <= op_count + 8'd1;
        end
    end

    // operand snapshot and result hold
    always_ff @(posedge clk)
    begin
        if (state_q == ST_IDLE && start)
            ops_q <= operands;
        if (core_valid)
            held_value_q <= core_result;
    end

    assign busy = (state_q != ST_IDLE);

endmodule

//--- verilog/rnd_result_fifo.sv
// --------------------------------------
// tagged result FIFO
// --------------------------------------
`include "ecc_rnd_settings.svh"

module rnd_result_fifo
(
    input  logic                     clk,
    input  logic                     reset_n,
    input  logic                     push,
    input  logic                     pop,
    input  ecc_rnd_pkg::rnd_result_t push_data,
    output ecc_rnd_pkg::rnd_result_t head,
    output logic                     full,
    output logic                     empty,
    output logic [2:0]               count
);

    localparam int DEPTH = `ECC_RND_FIFO_DEPTH;
    localparam int AW    = $clog2(DEPTH);

    ecc_rnd_pkg::rnd_result_t mem [DEPTH];
    logic [AW-1:0]            wr_ptr_q;
    logic [AW-1:0]            rd_ptr_q;
    logic                     do_push;
    logic                     do_pop;

    // drop requests that would overflow or underflow
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    // pointers and fill level
    always_ff @(posedge clk or negedge reset_n)
    begin
        if (!reset_n)
        begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count    <= '0;
        end
        else
        begin
            if (do_push)
                wr_ptr_q <= (wr_ptr_q == AW'(DEPTH - 1)) ? '0 : wr_ptr_q + AW'(1);
            if (do_pop)
                rd_ptr_q <= (rd_ptr_q == AW'(DEPTH - 1)) ? '0 : rd_ptr_q + AW'(1);
            // simultaneous push and pop keeps the level
            if (do_push && !do_pop)
                count <= count + 3'd1;
            else if (do_pop && !do_push)
                count <= count - 3'd1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (do_push)
            mem[wr_ptr_q] <= push_data;
    end

    assign head  = mem[rd_ptr_q];
    assign full  = (count == 3'(DEPTH));
    assign empty = (count == 3'd0);

endmodule

//--- verilog/ecc_rnd_apb_regs.sv
// --------------------------------------
// APB register block: operands, CTRL,
// STATUS and RESULT pop
// --------------------------------------
`include "ecc_rnd_settings.svh"

module ecc_rnd_apb_regs
(
    input  logic                       clk,
    input  logic                       reset_n,
    input  logic                       psel,
    input  logic                       penable,
    input  logic                       pwrite,
    input  logic [7:0]                 paddr,
    input  logic [`ECC_RND_W-1:0]      pwdata,
    output logic [`ECC_RND_W-1:0]      prdata,
    output logic                       pready,
    output logic                       pslverr,
    output logic                       start,
    output ecc_rnd_pkg::rnd_operands_t operands,
    input  logic                       busy,
    input  logic [7:0]                 op_count,
    input  ecc_rnd_pkg::rnd_result_t   head,
    input  logic                       empty,
    input  logic [2:0]                 count,
    output logic                       pop
);

    logic       access;
    logic       wr_en;
    logic       rd_en;
    logic       mapped;
    logic       ctrl_start;
    logic [2:0] head_kind;

    // access phase, zero wait states
    assign access = psel && penable;
    assign wr_en  = access && pwrite;
    assign rd_en  = access && !pwrite;
    assign pready = 1'b1;

    assign mapped     = (paddr[1:0] == 2'b00) && (paddr <= `ECC_RND_ADDR_RESULT);
    assign ctrl_start = wr_en && (paddr == `ECC_RND_ADDR_CTRL) && pwdata[0];

    // error on bad address, empty pop, or start while busy
    assign pslverr = access && (!mapped ||
                                (rd_en && paddr == `ECC_RND_ADDR_RESULT && empty) ||
                                (ctrl_start && busy));

    assign pop = rd_en && (paddr == `ECC_RND_ADDR_RESULT) && !empty;

    // --------------------------------------
    // operand registers and start pulse
    // --------------------------------------
    always_ff @(posedge clk or negedge reset_n)
    begin
        if (!reset_n)
        begin
            operands <= '0;
            start    <= 1'b0;
        end
        else
        begin
            // start lands with mode already written
            start <= ctrl_start && !busy;
            if (wr_en)
            begin
                case (paddr)
                    `ECC_RND_ADDR_CTRL:    operands.keygen_sign <= pwdata[1];
                    `ECC_RND_ADDR_IV:      operands.iv          <= pwdata;
                    `ECC_RND_ADDR_SEED:    operands.seed        <= pwdata;
                    `ECC_RND_ADDR_NONCE:   operands.nonce       <= pwdata;
                    `ECC_RND_ADDR_PRIVKEY: operands.privkey     <= pwdata;
                    `ECC_RND_ADDR_HASH:    operands.hash        <= pwdata;
                    default:               ;
                endcase
            end
        end
    end

    // stale head not shown while empty
    assign head_kind = empty ? 3'd0 : head.kind;

    // read mux
    always_comb
    begin
        prdata = '0;
        if (rd_en)
        begin
            case (paddr)
                `ECC_RND_ADDR_STATUS:  prdata = {16'd0, op_count, 1'b0, head_kind, count, busy};
                `ECC_RND_ADDR_IV:      prdata = operands.iv;
                `ECC_RND_ADDR_SEED:    prdata = operands.seed;
                `ECC_RND_ADDR_NONCE:   prdata = operands.nonce;
                `ECC_RND_ADDR_PRIVKEY: prdata = operands.privkey;
                `ECC_RND_ADDR_HASH:    prdata = operands.hash;
                `ECC_RND_ADDR_RESULT:  prdata = empty ? '0 : head.value;
                default:               prdata = '0;
            endcase
        end
    end

endmodule

//--- verilog/ecc_rnd_top.sv
// --------------------------------------
// randomness sequencer top level
// --------------------------------------
`include "ecc_rnd_settings.svh"

module ecc_rnd_top
(
    input  logic                  clk,
    input  logic                  reset_n,
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  logic [7:0]            paddr,
    input  logic [`ECC_RND_W-1:0] pwdata,
    output logic [`ECC_RND_W-1:0] prdata,
    output logic                  pready,
    output logic                  pslverr
);

    // register block to sequencer
    logic                       start;
    ecc_rnd_pkg::rnd_operands_t operands;
    logic                       busy;
    logic [7:0]                 op_count;

    // sequencer to core
    ecc_rnd_pkg::drbg_cmd_t     core_cmd;
    logic                       core_ready;
    logic                       core_valid;
    logic [`ECC_RND_W-1:0]      core_result;

    // result FIFO
    logic                       push;
    logic                       pop;
    ecc_rnd_pkg::rnd_result_t   push_data;
    ecc_rnd_pkg::rnd_result_t   head;
    logic                       full;
    logic                       empty;
    logic [2:0]                 count;

    ecc_rnd_apb_regs u_regs
    (
        .clk      (clk),
        .reset_n  (reset_n),
        .psel     (psel),
        .penable  (penable),
        .pwrite   (pwrite),
        .paddr    (paddr),
        .pwdata   (pwdata),
        .prdata   (prdata),
        .pready   (pready),
        .pslverr  (pslverr),
        .start    (start),
        .operands (operands),
        .busy     (busy),
        .op_count (op_count),
        .head     (head),
        .empty    (empty),
        .count    (count),
        .pop      (pop)
    );

    drbg_sequencer u_seq
    (
        .clk         (clk),
        .reset_n     (reset_n),
        .start       (start),
        .operands    (operands),
        .core_ready  (core_ready),
        .core_valid  (core_valid),
        .core_result (core_result),
        .core_cmd    (core_cmd),
        .push        (push),
        .push_data   (push_data),
        .fifo_full   (full),
        .busy        (busy),
        .op_count    (op_count)
    );

    drbg_core u_core
    (
        .clk     (clk),
        .reset_n (reset_n),
        .cmd     (core_cmd),
        .ready   (core_ready),
        .valid   (core_valid),
        .result  (core_result)
    );

    rnd_result_fifo u_fifo
    (
        .clk       (clk),
        .reset_n   (reset_n),
        .push      (push),
        .pop       (pop),
        .push_data (push_data),
        .head      (head),
        .full      (full),
        .empty     (empty),
        .count     (count)
    );

endmodule

//--- dv/tb_clock_gen.sv
// --------------------------------------
// testbench clock, 100 ns period, and
// reset held low for 10 cycles
// --------------------------------------

module tb_clock_gen
(
    output logic clk,
    output logic reset_n
);
    timeunit 1ns;
    timeprecision 1ps;

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // release on a falling edge, away from the DUT sampling edge
    initial
    begin
        reset_n = 1'b0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        reset_n = 1'b1;
    end

endmodule

//--- dv/tb_ecc_rnd_checker.sv
// --------------------------------------
// APB monitor with a reference model of
// the core and sequence rules
// --------------------------------------
`include "ecc_rnd_settings.svh"

module tb_ecc_rnd_checker
(
    input  logic                  clk,
    input  logic                  reset_n,
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  logic [7:0]            paddr,
    input  logic [`ECC_RND_W-1:0] pwdata,
    input  logic [`ECC_RND_W-1:0] prdata,
    input  logic                  pready,
    input  logic                  pslverr,
    input  logic                  exp_err,
    output int                    value_errs,
    output int                    proto_errs
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int DEPTH = `ECC_RND_FIFO_DEPTH;

    // shadow copies of the operand registers
    logic [31:0] sh_iv;
    logic [31:0] sh_seed;
    logic [31:0] sh_nonce;
    logic [31:0] sh_privkey;
    logic [31:0] sh_hash;
    // accepted starts, mirrors op_count
    logic [7:0]  ops_started;
    // generator model state
    logic [31:0] model_key;
    logic [31:0] model_ctr;
    ecc_rnd_pkg::rnd_result_t exp_q[$];

    initial
    begin
        value_errs  = 0;
        proto_errs  = 0;
        sh_iv       = '0;
        sh_seed     = '0;
        sh_nonce    = '0;
        sh_privkey  = '0;
        sh_hash     = '0;
        ops_started = '0;
        model_key   = '0;
        model_ctr   = '0;
    end

    // --------------------------------------
    // reference model
    // --------------------------------------
    // all rounds of the keyed mixer
    function automatic logic [31:0] mix_rounds(input logic [31:0] x);
        logic [31:0] t;
        t = x;
        for (int r = 0; r < `ECC_RND_ROUNDS; r++)
        begin
            t = t ^ (t << 13);
            t = t ^ (t >> 17);
            t = t ^ (t << 5);
        end
        return t;
    endfunction

    task automatic expect_result(input ecc_rnd_pkg::rnd_kind_e kind);
        ecc_rnd_pkg::rnd_result_t r;
        r.kind  = kind;
        r.value = mix_rounds(model_key ^ (model_ctr + 32'd1));
        exp_q.push_back(r);
    endtask

    // init rekeys with the nonce rotated by 16
    task automatic model_init(input logic [31:0] e, input logic [31:0] n,
                              input ecc_rnd_pkg::rnd_kind_e kind);
        model_key = e ^ {n[15:0], n[31:16]};
        model_ctr = '0;
        expect_result(kind);
    endtask

    task automatic model_next(input ecc_rnd_pkg::rnd_kind_e kind);
        model_ctr = model_ctr + 32'd1;
        expect_result(kind);
    endtask

    task automatic model_operation(input logic sign);
        model_init(sh_iv, {24'd0, ops_started}, ecc_rnd_pkg::LAMBDA);
        model_next(ecc_rnd_pkg::SCALAR_RND);
        if (sign)
        begin
            model_next(ecc_rnd_pkg::MASKING_RND);
            model_init(sh_privkey, sh_hash, ecc_rnd_pkg::SIGN_K);
        end
        else
        begin
            model_init(sh_seed, sh_nonce, ecc_rnd_pkg::PRIVKEY);
        end
        ops_started = ops_started + 8'd1;
    endtask

    // --------------------------------------
    // compare helpers
    // --------------------------------------
    task automatic compare_word(input string what, input logic [31:0] got,
                                input logic [31:0] exp);
        if (got !== exp)
        begin
            value_errs++;
            $display("ERR %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    // busy and count depend on latency, so bounds only while busy
    task automatic check_status(input logic [31:0] s);
        logic [7:0] prev_ops;
        int         limit;
        logic [2:0] exp_kind;
        prev_ops = ops_started - 8'd1;
        limit    = (exp_q.size() > DEPTH) ? DEPTH : exp_q.size();
        exp_kind = 3'd0;
        if (s[3:1] != 3'd0 && exp_q.size() > 0)
            exp_kind = exp_q[0].kind;
        compare_word("status reserved bits", {s[31:16], s[7]}, 32'd0);
        compare_word("status head kind", s[6:4], exp_kind);
        if (s[0])
        begin
            compare_word("status op_count while busy", s[15:8], prev_ops);
            if (s[3:1] > limit)
                compare_word("status count while busy", s[3:1], limit);
        end
        else
        begin
            compare_word("status op_count", s[15:8], ops_started);
            compare_word("status count when idle", s[3:1], exp_q.size());
        end
    endtask

    // --------------------------------------
    // bus monitor, access phase only
    // --------------------------------------
    always @(posedge clk)
    begin
        if (reset_n && psel && penable)
        begin
            if (pslverr !== exp_err || pready !== 1'b1)
            begin
                proto_errs++;
                $display("ERR %0t: addr %h pslverr %b pready %b, expected pslverr %b",
                         $time, paddr, pslverr, pready, exp_err);
            end
            if (pwrite)
            begin
                case (paddr)
                    `ECC_RND_ADDR_CTRL:
                        if (pwdata[0] && !exp_err)
                            model_operation(pwdata[1]);
                    `ECC_RND_ADDR_IV:      sh_iv      = pwdata;
                    `ECC_RND_ADDR_SEED:    sh_seed    = pwdata;
                    `ECC_RND_ADDR_NONCE:   sh_nonce   = pwdata;
                    `ECC_RND_ADDR_PRIVKEY: sh_privkey = pwdata;
                    `ECC_RND_ADDR_HASH:    sh_hash    = pwdata;
                    default:               ;
                endcase
            end
            else
            begin
                case (paddr)
                    `ECC_RND_ADDR_STATUS:  check_status(prdata);
                    `ECC_RND_ADDR_IV:      compare_word("iv readback", prdata, sh_iv);
                    `ECC_RND_ADDR_SEED:    compare_word("seed readback", prdata, sh_seed);
                    `ECC_RND_ADDR_NONCE:   compare_word("nonce readback", prdata, sh_nonce);
                    `ECC_RND_ADDR_PRIVKEY: compare_word("privkey readback", prdata, sh_privkey);
                    `ECC_RND_ADDR_HASH:    compare_word("hash readback", prdata, sh_hash);
                    `ECC_RND_ADDR_RESULT:
                        if (!exp_err)
                        begin
                            if (exp_q.size() == 0)
                            begin
                                value_errs++;
                                $display("ERR %0t: result %h read with none expected",
                                         $time, prdata);
                            end
                            else
                            begin
                                compare_word("result value", prdata, exp_q[0].value);
                                void'(exp_q.pop_front());
                            end
                        end
                    default:               ;
                endcase
            end
        end
    end

endmodule

//--- dv/tb_ecc_rnd.sv
// --------------------------------------
// testbench top: operation table, APB
// driver tasks, DUT and checker
// --------------------------------------
`include "ecc_rnd_settings.svh"

module tb_ecc_rnd;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int N_OPS      = 6;
    localparam int DEPTH      = `ECC_RND_FIFO_DEPTH;
    localparam int POLL_LIMIT = 100;

    // one row of the operation table
    typedef struct packed
    {
        logic        sign;
        logic [31:0] iv;
        logic [31:0] seed;
        logic [31:0] nonce;
        logic [31:0] privkey;
        logic [31:0] hash;
        logic        drain;
    } op_entry_t;

    op_entry_t   ops [N_OPS];
    logic        clk;
    logic        reset_n;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [7:0]  paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    logic        exp_err;
    int          value_errs;
    int          proto_errs;
    int          timeouts;
    int          pending;
    int          reset_wait;
    logic        aborted;
    logic [31:0] rng_state;
    logic [31:0] rd;

    tb_clock_gen clk0
    (
        .clk     (clk),
        .reset_n (reset_n)
    );

    ecc_rnd_top dut0
    (
        .clk     (clk),
        .reset_n (reset_n),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    tb_ecc_rnd_checker chk0
    (
        .clk        (clk),
        .reset_n    (reset_n),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .paddr      (paddr),
        .pwdata     (pwdata),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr),
        .exp_err    (exp_err),
        .value_errs (value_errs),
        .proto_errs (proto_errs)
    );

    // xorshift32 operand source
    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    task automatic set_entry(input int idx, input logic sign, input logic drain,
                             input logic [31:0] iv, input logic [31:0] seed,
                             input logic [31:0] nonce, input logic [31:0] privkey,
                             input logic [31:0] hash);
        ops[idx].sign    = sign;
        ops[idx].drain   = drain;
        ops[idx].iv      = iv;
        ops[idx].seed    = seed;
        ops[idx].nonce   = nonce;
        ops[idx].privkey = privkey;
        ops[idx].hash    = hash;
    endtask

    // --------------------------------------
    // APB driver, inputs change on negedge
    // --------------------------------------
    task automatic apb_xfer(input logic write, input logic [7:0] addr,
                            input logic [31:0] data, input logic expect_error,
                            output logic [31:0] rdata);
        rdata = '0;
        if (!aborted)
        begin
            @(negedge clk);
            psel    = 1'b1;
            penable = 1'b0;
            pwrite  = write;
            paddr   = addr;
            pwdata  = data;
            exp_err = expect_error;
            @(negedge clk);
            penable = 1'b1;
            // transfer completes on this edge
            @(posedge clk);
            rdata = prdata;
            @(negedge clk);
            psel    = 1'b0;
            penable = 1'b0;
            exp_err = 1'b0;
        end
    endtask

    // poll STATUS until (status & mask) == want
    task automatic poll_status(input logic [31:0] mask, input logic [31:0] want,
                               input string what);
        logic [31:0] s;
        int          tries;
        logic        hit;
        tries = 0;
        hit   = 1'b0;
        while (!hit && !aborted && tries < POLL_LIMIT)
        begin
            apb_xfer(1'b0, `ECC_RND_ADDR_STATUS, '0, 1'b0, s);
            hit = ((s & mask) == want);
            tries++;
        end
        if (!hit && !aborted)
        begin
            $display("timeout: %s not seen after %0d STATUS polls", what, POLL_LIMIT);
            timeouts++;
            aborted = 1'b1;
        end
    endtask

    // read back in batches the FIFO can hold
    task automatic drain_results();
        logic [31:0] r;
        int          batch;
        while (pending > 0 && !aborted)
        begin
            batch = (pending > DEPTH) ? DEPTH : pending;
            poll_status(32'h0000_000E, 32'(batch << 1), "result FIFO fill");
            repeat (batch)
            begin
                // head kind shows in STATUS before each pop
                apb_xfer(1'b0, `ECC_RND_ADDR_STATUS, '0, 1'b0, r);
                apb_xfer(1'b0, `ECC_RND_ADDR_RESULT, '0, 1'b0, r);
            end
            pending = pending - batch;
        end
        poll_status(32'h1, 32'h0, "busy falling after drain");
    endtask

    task automatic run_op(input op_entry_t e);
        logic [31:0] r;
        apb_xfer(1'b1, `ECC_RND_ADDR_IV, e.iv, 1'b0, r);
        apb_xfer(1'b1, `ECC_RND_ADDR_SEED, e.seed, 1'b0, r);
        apb_xfer(1'b1, `ECC_RND_ADDR_NONCE, e.nonce, 1'b0, r);
        apb_xfer(1'b1, `ECC_RND_ADDR_PRIVKEY, e.privkey, 1'b0, r);
        apb_xfer(1'b1, `ECC_RND_ADDR_HASH, e.hash, 1'b0, r);
        apb_xfer(1'b1, `ECC_RND_ADDR_CTRL, {30'd0, e.sign, 1'b1}, 1'b0, r);
        pending = pending + (e.sign ? 4 : 3);
        // undrained results stay queued for a later run
        if (e.drain)
            drain_results();
        else
            poll_status(32'h1, 32'h0, "busy falling");
    endtask

    // --------------------------------------
    // main sequence
    // --------------------------------------
    initial
    begin
        psel       = 1'b0;
        penable    = 1'b0;
        pwrite     = 1'b0;
        paddr      = '0;
        pwdata     = '0;
        exp_err    = 1'b0;
        aborted    = 1'b0;
        timeouts   = 0;
        pending    = 0;
        reset_wait = 0;
        rng_state  = 32'd68;

        set_entry(0, 1'b0, 1'b1, 32'h0123_4567, 32'h89ab_cdef, 32'h0f1e_2d3c,
                  32'h4b5a_6978, 32'hdead_beef);
        set_entry(1, 1'b1, 1'b1, next_rand(), next_rand(), next_rand(), next_rand(),
                  next_rand());
        // same operands again, lambda must move with op_count
        ops[2] = ops[0];
        // keygen left in the FIFO, then a sign run hits a full FIFO
        set_entry(3, 1'b0, 1'b0, next_rand(), next_rand(), next_rand(), next_rand(),
                  next_rand());
        set_entry(4, 1'b1, 1'b1, next_rand(), next_rand(), next_rand(), next_rand(),
                  next_rand());
        set_entry(5, 1'b1, 1'b1, next_rand(), next_rand(), next_rand(), next_rand(),
                  next_rand());

        while (reset_n !== 1'b1 && reset_wait < 20)
        begin
            @(negedge clk);
            reset_wait++;
        end
        if (reset_n !== 1'b1)
        begin
            $display("timeout: reset never released");
            timeouts++;
            aborted = 1'b1;
        end

        // reset values of STATUS and the operand registers
        for (int a = `ECC_RND_ADDR_STATUS; a <= `ECC_RND_ADDR_HASH; a += 4)
            apb_xfer(1'b0, 8'(a), '0, 1'b0, rd);

        for (int i = 0; i < N_OPS && !aborted; i++)
            run_op(ops[i]);

        // error responses
        apb_xfer(1'b0, `ECC_RND_ADDR_RESULT, '0, 1'b1, rd);
        apb_xfer(1'b0, 8'h20, '0, 1'b1, rd);
        apb_xfer(1'b1, 8'h22, 32'h5a5a_5a5a, 1'b1, rd);

        // second start while busy is refused
        apb_xfer(1'b1, `ECC_RND_ADDR_IV, next_rand(), 1'b0, rd);
        apb_xfer(1'b1, `ECC_RND_ADDR_CTRL, 32'h1, 1'b0, rd);
        poll_status(32'h1, 32'h1, "busy rising");
        apb_xfer(1'b1, `ECC_RND_ADDR_CTRL, 32'h1, 1'b1, rd);
        pending = pending + 3;
        drain_results();
        apb_xfer(1'b0, `ECC_RND_ADDR_STATUS, '0, 1'b0, rd);

        @(negedge clk);
        $display("errors: value %0d, bus response %0d, timeouts %0d",
                 value_errs, proto_errs, timeouts);
        if (value_errs == 0 && proto_errs == 0 && timeouts == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

endmodule

//--- sim.f
+incdir+verilog
verilog/ecc_rnd_pkg.sv
verilog/drbg_core.sv
verilog/drbg_sequencer.sv
verilog/rnd_result_fifo.sv
verilog/ecc_rnd_apb_regs.sv
verilog/ecc_rnd_top.sv
dv/tb_clock_gen.sv
dv/tb_ecc_rnd_checker.sv
dv/tb_ecc_rnd.sv
